/* tb.f */
verilog/accel_pkg.sv
verilog/mmio_regs.sv
verilog/pkt_mem.sv
verilog/line_rd_dma.sv
verilog/width_conv_buf.sv
verilog/byte_match.sv
verilog/accel_top.sv
dv/accel_tb.sv

/* dv/accel_tb.sv */
`timescale 1ns/10ps

module accel_tb;

  localparam int TIMEOUT_CYCLES = 20000;
  localparam logic [accel_pkg::IO_DATA_WIDTH-1:0] NO_MATCH_WORD = 32'h0000_ffff;

  logic               clk;
  logic               rst;
  accel_pkg::io_req_t req;
  logic [accel_pkg::IO_DATA_WIDTH-1:0] rd_data;
  logic               rd_valid;

  integer     seed;
  int         errors;
  int         cycle_count;
  logic [7:0] pkt_bytes [256];

  accel_top #(.MEM_LINES(256), .FIFO_LINES(4)) UUT (
    .clk(clk), .rst(rst), .req(req), .rd_data(rd_data), .rd_valid(rd_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // watchdog over the whole run
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic io_write(input logic [accel_pkg::IO_ADDR_WIDTH-1:0] addr,
                          input logic [accel_pkg::IO_DATA_WIDTH-1:0] data,
                          input logic [accel_pkg::IO_STRB_WIDTH-1:0] strb);
    req = '{en: 1'b1, wen: 1'b1, strb: strb, addr: addr, wr_data: data};
    @(posedge clk);
    #1;
    req = '0;
  endtask

  // address stays on the bus until rd_valid, which covers the FIRST stall
  task automatic io_read(input logic [accel_pkg::IO_ADDR_WIDTH-1:0] addr,
                         output logic [accel_pkg::IO_DATA_WIDTH-1:0] data,
                         output int waited);
    req = '{en: 1'b1, wen: 1'b0, strb: '0, addr: addr, wr_data: '0};
    waited = 0;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!rd_valid);
    data = rd_data;
    req = '0;
  endtask

  // byte k of the packet sits in line k/16, lane (k/4)%4, byte lane k%4
  task automatic mem_load(input int line, input int n);
    logic [accel_pkg::IO_DATA_WIDTH-1:0] data;
    logic [accel_pkg::IO_STRB_WIDTH-1:0] strb;
    logic [accel_pkg::IO_ADDR_WIDTH-1:0] addr;
    for (int i = 0; i < n; i += 4) begin
      data = '0;
      strb = '0;
      for (int b = 0; b < 4; b++) begin
        if (i + b < n) begin
          data[8*b +: 8] = pkt_bytes[i+b];
          strb[b] = 1'b1;
        end
      end
      addr = {1'b1, 8'(line + i / 16), 2'((i / 4) % 4), 2'b00};
      io_write(addr, data, strb);
    end
  endtask

  task automatic fill_random(input int n, input logic [7:0] pat, input bit avoid);
    for (int i = 0; i < n; i++) begin
      pkt_bytes[i] = 8'($random(seed));
      if (avoid && pkt_bytes[i] == pat) begin
        pkt_bytes[i] = ~pat;
      end
    end
  endtask

  // reference model over the first n packet bytes
  task automatic expected_scan(input int n, input logic [7:0] pat,
                               output logic [accel_pkg::IO_DATA_WIDTH-1:0] cnt,
                               output logic [accel_pkg::IO_DATA_WIDTH-1:0] first);
    cnt = '0;
    first = NO_MATCH_WORD;
    for (int i = 0; i < n; i++) begin
      if (pkt_bytes[i] == pat) begin
        if (cnt == 0) begin
          first = i;
        end
        cnt++;
      end
    end
  endtask

  task automatic check_rd(input string name,
                          input logic [accel_pkg::IO_DATA_WIDTH-1:0] expected,
                          input logic [accel_pkg::IO_DATA_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
      errors++;
    end
  endtask

  // compares busy, done and match from a CTRL read
  task automatic check_status(input string name, input logic busy, input logic done,
                              input logic match,
                              input logic [accel_pkg::IO_DATA_WIDTH-1:0] ctrl);
    if ({ctrl[1], ctrl[8], ctrl[9]} !== {busy, done, match}) begin
      $display("Error: %s expected busy=%0b done=%0b match=%0b actual busy=%0b done=%0b match=%0b",
               name, busy, done, match, ctrl[1], ctrl[8], ctrl[9]);
      errors++;
    end
  endtask

  // cycles from read request to rd_valid
  task automatic check_latency(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("Error: %s expected %0d cycles actual %0d cycles", name, expected, actual);
      errors++;
    end
  endtask

  task automatic start_scan(input int line, input int len, input logic [7:0] pat);
    io_write(accel_pkg::REG_LEN, len, 4'hf);
    io_write(accel_pkg::REG_ADDR, line, 4'hf);
    io_write(accel_pkg::REG_PATTERN, pat, 4'hf);
    io_write(accel_pkg::REG_CTRL, 32'h1, 4'hf);
  endtask

  // one idle cycle first so the done bit of the previous scan is cleared
  task automatic wait_done();
    logic [accel_pkg::IO_DATA_WIDTH-1:0] ctrl;
    int waited;
    idle(1);
    do begin
      io_read(accel_pkg::REG_CTRL, ctrl, waited);
    end while (!ctrl[8]);
  endtask

  task automatic scan_and_compare(input string name, input int line, input int len,
                                  input logic [7:0] pat);
    logic [accel_pkg::IO_DATA_WIDTH-1:0] exp_cnt;
    logic [accel_pkg::IO_DATA_WIDTH-1:0] exp_first;
    logic [accel_pkg::IO_DATA_WIDTH-1:0] value;
    int waited;
    expected_scan(len, pat, exp_cnt, exp_first);
    start_scan(line, len, pat);
    wait_done();
    io_read(accel_pkg::REG_COUNT, value, waited);
    check_rd({name, " COUNT"}, exp_cnt, value);
    io_read(accel_pkg::REG_FIRST, value, waited);
    check_rd({name, " FIRST"}, exp_first, value);
    // scan has ended, so FIRST must not stall
    check_latency({name, " FIRST latency"}, 1, waited);
    io_read(accel_pkg::REG_CTRL, value, waited);
    check_status({name, " CTRL"}, 1'b0, 1'b1, exp_cnt != 0, value);
  endtask

  task automatic registers_after_reset();
    logic [accel_pkg::IO_DATA_WIDTH-1:0] value;
    int waited;
    io_read(accel_pkg::REG_CTRL, value, waited);
    check_rd("registers CTRL", 32'h0, value);
    check_latency("registers CTRL latency", 1, waited);
    io_write(accel_pkg::REG_LEN, 32'd37, 4'hf);
    io_write(accel_pkg::REG_ADDR, 32'd5, 4'hf);
    io_write(accel_pkg::REG_PATTERN, 32'ha5, 4'hf);
    io_read(accel_pkg::REG_LEN, value, waited);
    check_rd("registers LEN", 32'd37, value);
    check_latency("registers LEN latency", 1, waited);
    io_read(accel_pkg::REG_ADDR, value, waited);
    check_rd("registers ADDR", 32'd5, value);
    io_read(accel_pkg::REG_PATTERN, value, waited);
    check_rd("registers PATTERN", 32'ha5, value);
  endtask

  task automatic single_line_scan();
    logic [accel_pkg::IO_DATA_WIDTH-1:0] value;
    int waited;
    for (int i = 0; i < 16; i++) begin
      pkt_bytes[i] = 8'h10 + 8'(i);
    end
    pkt_bytes[4]  = 8'h3c;
    pkt_bytes[9]  = 8'h3c;
    pkt_bytes[15] = 8'h3c;
    mem_load(0, 16);
    start_scan(0, 16, 8'h3c);
    wait_done();
    io_read(accel_pkg::REG_COUNT, value, waited);
    check_rd("single line COUNT", 32'd3, value);
    io_read(accel_pkg::REG_FIRST, value, waited);
    check_rd("single line FIRST", 32'd4, value);
    io_read(accel_pkg::REG_CTRL, value, waited);
    check_status("single line CTRL", 1'b0, 1'b1, 1'b1, value);
  endtask

  // pattern bytes just past the length must not be counted
  task automatic multi_line_scan();
    fill_random(48, 8'h5a, 1'b1);
    pkt_bytes[20] = 8'h5a;
    pkt_bytes[29] = 8'h5a;
    pkt_bytes[37] = 8'h5a;
    pkt_bytes[40] = 8'h5a;
    mem_load(10, 48);
    scan_and_compare("multi line", 10, 37, 8'h5a);
  endtask

  task automatic absent_pattern_scan();
    fill_random(32, 8'hc3, 1'b1);
    mem_load(20, 32);
    scan_and_compare("no match", 20, 32, 8'hc3);
  endtask

  task automatic stop_and_rescan();
    logic [accel_pkg::IO_DATA_WIDTH-1:0] value;
    int waited;
    fill_random(200, 8'h77, 1'b1);
    mem_load(40, 200);
    start_scan(40, 200, 8'h77);
    io_write(accel_pkg::REG_CTRL, 32'h10, 4'hf);
    idle(1);
    io_read(accel_pkg::REG_CTRL, value, waited);
    check_status("stop CTRL", 1'b0, 1'b1, 1'b0, value);
    fill_random(25, 8'h21, 1'b0);
    pkt_bytes[7] = 8'h21;
    mem_load(60, 25);
    scan_and_compare("scan after stop", 60, 25, 8'h21);
  endtask

  task automatic stalled_first_read();
    logic [accel_pkg::IO_DATA_WIDTH-1:0] exp_cnt;
    logic [accel_pkg::IO_DATA_WIDTH-1:0] exp_first;
    logic [accel_pkg::IO_DATA_WIDTH-1:0] value;
    int waited;
    fill_random(64, 8'h9e, 1'b0);
    pkt_bytes[33] = 8'h9e;
    mem_load(80, 64);
    expected_scan(64, 8'h9e, exp_cnt, exp_first);
    start_scan(80, 64, 8'h9e);
    io_read(accel_pkg::REG_FIRST, value, waited);
    if (waited < 2) begin
      $display("stalled read: FIRST came back without waiting for the scan to end");
      errors++;
    end
    check_rd("stalled read FIRST", exp_first, value);
    io_read(accel_pkg::REG_CTRL, value, waited);
    check_status("stalled read CTRL", 1'b0, 1'b1, exp_cnt != 0, value);
  endtask

  initial begin
    seed = 32'h6e5d_eebe;
    errors = 0;
    cycle_count = 0;
    req = '0;
    rst = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    idle(2);

    registers_after_reset();
    single_line_scan();
    multi_line_scan();
    absent_pattern_scan();
    stop_and_rescan();
    stalled_first_read();

    idle(2);
    $display("Summary: %0d errors after %0d cycles", errors, cycle_count);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* verilog/accel_top.sv */
`timescale 1ns/10ps

module accel_top #(
  parameter int MEM_LINES  = 256,
  parameter int FIFO_LINES = 4
) (
  input  logic                                clk,
  input  logic                                rst,
  input  accel_pkg::io_req_t                  req,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0] rd_data,
  output logic                                rd_valid
);

  accel_pkg::scan_status_t               status;
  accel_pkg::dma_desc_t                  desc;
  logic [7:0]                            pattern;
  logic                                  start;
  logic                                  stop;
  logic                                  mem_we;
  logic [accel_pkg::LINE_ADDR_WIDTH-1:0] mem_line;
  logic [accel_pkg::LANE_WIDTH-1:0]      mem_lane;
  logic [accel_pkg::IO_STRB_WIDTH-1:0]   mem_strb;
  logic [accel_pkg::IO_DATA_WIDTH-1:0]   mem_wdata;
  logic                                  mem_rd_en;
  logic [accel_pkg::LINE_ADDR_WIDTH-1:0] mem_rd_line;
  logic [accel_pkg::LINE_WIDTH-1:0]      mem_rd_data;
  accel_pkg::line_beat_t                 line_beat;
  logic                                  line_valid;
  accel_pkg::word_beat_t                 word_beat;
  logic                                  word_valid;

  mmio_regs regs (
    .clk(clk), .rst(rst), .req(req), .status(status),
    .rd_data(rd_data), .rd_valid(rd_valid),
    .desc(desc), .pattern(pattern), .start(start), .stop(stop),
    .mem_we(mem_we), .mem_line(mem_line), .mem_lane(mem_lane),
    .mem_strb(mem_strb), .mem_wdata(mem_wdata)
  );

  pkt_mem #(.MEM_LINES(MEM_LINES)) mem (
    .clk(clk), .we(mem_we), .wr_line(mem_line), .wr_lane(mem_lane),
    .wr_strb(mem_strb), .wr_data(mem_wdata),
    .rd_en(mem_rd_en), .rd_line(mem_rd_line), .rd_data(mem_rd_data)
  );

  line_rd_dma dma (
    .clk(clk), .rst(rst), .desc(desc), .start(start), .stop(stop),
    .mem_rd_en(mem_rd_en), .mem_rd_line(mem_rd_line), .mem_rd_data(mem_rd_data),
    .beat(line_beat), .beat_valid(line_valid)
  );

  width_conv_buf #(.FIFO_LINES(FIFO_LINES)) conv (
    .clk(clk), .rst(rst), .flush(stop),
    .in_beat(line_beat), .in_valid(line_valid),
    .out_beat(word_beat), .out_valid(word_valid)
  );

  byte_match match (
    .clk(clk), .rst(rst), .start(start), .stop(stop), .pattern(pattern),
    .word(word_beat), .word_valid(word_valid), .status(status)
  );

endmodule

/* verilog/byte_match.sv */
`timescale 1ns/10ps

module byte_match (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  logic                    stop,
  input  logic [7:0]              pattern,
  input  accel_pkg::word_beat_t   word,
  input  logic                    word_valid,
  output accel_pkg::scan_status_t status
);

  localparam int KEEP_WIDTH = accel_pkg::WORD_WIDTH / 8;
  localparam int POS_WIDTH  = $clog2(KEEP_WIDTH);
  localparam int CNT_WIDTH  = POS_WIDTH + 1;

  logic [7:0]                      pat_q;
  logic                            busy_q;
  logic                            done_q;
  logic [accel_pkg::STAT_WIDTH-1:0] count_q;
  logic [accel_pkg::STAT_WIDTH-1:0] first_q;
  logic [accel_pkg::STAT_WIDTH-1:0] offset_q;
  logic [KEEP_WIDTH-1:0]           hit;
  logic [CNT_WIDTH-1:0]            hit_cnt;
  logic [CNT_WIDTH-1:0]            kept_cnt;
  logic [POS_WIDTH-1:0]            hit_pos;
  logic                            take;

  // walk from the top byte down so the lowest hit wins
  always_comb begin
    hit_cnt  = '0;
    kept_cnt = '0;
    hit_pos  = '0;
    for (int i = KEEP_WIDTH - 1; i >= 0; i--) begin
      hit[i]   = word.keep[i] && (word.data[8*i +: 8] == pat_q);
      hit_cnt  = hit_cnt + CNT_WIDTH'(hit[i]);
      kept_cnt = kept_cnt + CNT_WIDTH'(word.keep[i]);
      if (hit[i]) begin
        hit_pos = POS_WIDTH'(i);
      end
    end
  end

  assign take = word_valid && busy_q;

  always_ff @(posedge clk) begin
    if (start && !busy_q) begin
      pat_q <= pattern;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
      count_q  <= '0;
      first_q  <= accel_pkg::NO_MATCH;
      offset_q <= '0;
    end else if (start && !busy_q) begin
      busy_q   <= 1'b1;
      done_q   <= 1'b0;
      count_q  <= '0;
      first_q  <= accel_pkg::NO_MATCH;
      offset_q <= '0;
    end else if (stop) begin
      busy_q <= 1'b0;
      done_q <= 1'b1;
    end else if (take) begin
      count_q  <= count_q + accel_pkg::STAT_WIDTH'(hit_cnt);
      offset_q <= offset_q + accel_pkg::STAT_WIDTH'(kept_cnt);
      if (|hit && first_q == accel_pkg::NO_MATCH) begin
        first_q <= offset_q + accel_pkg::STAT_WIDTH'(hit_pos);
      end
      if (word.last) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  assign status = '{busy: busy_q, done: done_q, match: count_q != '0,
                    count: count_q, first_index: first_q};

endmodule

/* verilog/width_conv_buf.sv */
`timescale 1ns/10ps

module width_conv_buf #(
  parameter int FIFO_LINES = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush,
  input  accel_pkg::line_beat_t in_beat,
  input  logic                  in_valid,
  output accel_pkg::word_beat_t out_beat,
  output logic                  out_valid
);

  localparam int PTR_WIDTH  = $clog2(FIFO_LINES);
  localparam int WORD_BYTES = accel_pkg::WORD_WIDTH / 8;

  accel_pkg::line_beat_t fifo [FIFO_LINES];
  accel_pkg::line_beat_t head;

  logic [PTR_WIDTH-1:0]    wr_ptr;
  logic [PTR_WIDTH-1:0]    rd_ptr;
  logic [PTR_WIDTH:0]      fill;
  logic                    upper;
  logic                    two_words;
  logic                    pop;
  logic [2*WORD_BYTES:0]   mask;

  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(FIFO_LINES - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head      = fifo[rd_ptr];
  assign two_words = head.nbytes > 5'(WORD_BYTES);
  assign out_valid = fill != '0;
  // head line leaves after its low word, or its high word when it has one
  assign pop       = out_valid && (upper || !two_words);

  // byte mask over the whole line, split per word below
  assign mask = ((2*WORD_BYTES+1)'(1) << head.nbytes) - 1'b1;

  assign out_beat.data = upper ? head.data[accel_pkg::WORD_WIDTH +: accel_pkg::WORD_WIDTH]
                               : head.data[0 +: accel_pkg::WORD_WIDTH];
  assign out_beat.keep = upper ? mask[WORD_BYTES +: WORD_BYTES] : mask[0 +: WORD_BYTES];
  assign out_beat.last = head.last && pop;

  always_ff @(posedge clk) begin
    if (in_valid && !flush) begin
      fifo[wr_ptr] <= in_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
      upper  <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      upper <= out_valid && two_words && !upper;
      case ({in_valid, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

endmodule

/* verilog/line_rd_dma.sv */
`timescale 1ns/10ps

module line_rd_dma (
  input  logic                                  clk,
  input  logic                                  rst,
  input  accel_pkg::dma_desc_t                  desc,
  input  logic                                  start,
  input  logic                                  stop,
  output logic                                  mem_rd_en,
  output logic [accel_pkg::LINE_ADDR_WIDTH-1:0] mem_rd_line,
  input  logic [accel_pkg::LINE_WIDTH-1:0]      mem_rd_data,
  output accel_pkg::line_beat_t                 beat,
  output logic                                  beat_valid
);

  localparam int LINE_BYTES = accel_pkg::LINE_WIDTH / 8;

  logic                                  active;
  logic                                  gap;
  logic                                  pend;
  logic                                  pend_last;
  logic [4:0]                            pend_nbytes;
  logic [accel_pkg::LINE_ADDR_WIDTH-1:0] line_q;
  logic [accel_pkg::LEN_WIDTH-1:0]       rem_q;
  logic                                  final_chunk;
  logic [4:0]                            chunk;

  assign final_chunk = rem_q <= accel_pkg::LEN_WIDTH'(LINE_BYTES);
  assign chunk       = final_chunk ? rem_q[4:0] : 5'(LINE_BYTES);

  // one read every other cycle keeps the buffer from filling up
  assign mem_rd_en   = active && !gap;
  assign mem_rd_line = line_q;

  always_ff @(posedge clk) begin
    if (rst || stop) begin
      active <= 1'b0;
      gap    <= 1'b0;
      pend   <= 1'b0;
    end else begin
      pend <= mem_rd_en;
      if (start && !active) begin
        active <= desc.len != '0;
        gap    <= 1'b0;
      end else if (mem_rd_en) begin
        active <= !final_chunk;
        gap    <= 1'b1;
      end else begin
        gap <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start && !active) begin
      line_q <= desc.line_addr;
      rem_q  <= desc.len;
    end else if (mem_rd_en) begin
      line_q      <= line_q + 1'b1;
      rem_q       <= rem_q - accel_pkg::LEN_WIDTH'(chunk);
      pend_nbytes <= chunk;
      pend_last   <= final_chunk;
    end
  end

  // returned line is tagged with what was recorded at read time
  assign beat       = '{data: mem_rd_data, nbytes: pend_nbytes, last: pend_last};
  assign beat_valid = pend;

endmodule

/* verilog/pkt_mem.sv */
`timescale 1ns/10ps

module pkt_mem #(
  parameter int MEM_LINES = 256
) (
  input  logic                                  clk,
  input  logic                                  we,
  input  logic [accel_pkg::LINE_ADDR_WIDTH-1:0] wr_line,
  input  logic [accel_pkg::LANE_WIDTH-1:0]      wr_lane,
  input  logic [accel_pkg::IO_STRB_WIDTH-1:0]   wr_strb,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0]   wr_data,
  input  logic                                  rd_en,
  input  logic [accel_pkg::LINE_ADDR_WIDTH-1:0] rd_line,
  output logic [accel_pkg::LINE_WIDTH-1:0]      rd_data
);

  logic [accel_pkg::LINE_WIDTH-1:0] mem [MEM_LINES];

  // host side, one 32-bit lane per write under byte strobes
  always_ff @(posedge clk) begin
    if (we) begin
      for (int b = 0; b < accel_pkg::IO_STRB_WIDTH; b++) begin
        if (wr_strb[b]) begin
          mem[wr_line][wr_lane*accel_pkg::IO_DATA_WIDTH + 8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

  // dma side, data valid the cycle after rd_en
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_line];
    end
  end

endmodule

/* verilog/mmio_regs.sv */
`timescale 1ns/10ps

module mmio_regs (
  input  logic                                  clk,
  input  logic                                  rst,
  input  accel_pkg::io_req_t                    req,
  input  accel_pkg::scan_status_t               status,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0]   rd_data,
  output logic                                  rd_valid,
  output accel_pkg::dma_desc_t                  desc,
  output logic [7:0]                            pattern,
  output logic                                  start,
  output logic                                  stop,
  output logic                                  mem_we,
  output logic [accel_pkg::LINE_ADDR_WIDTH-1:0] mem_line,
  output logic [accel_pkg::LANE_WIDTH-1:0]      mem_lane,
  output logic [accel_pkg::IO_STRB_WIDTH-1:0]   mem_strb,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0]   mem_wdata
);

  localparam int MEM_SEL = accel_pkg::IO_ADDR_WIDTH - 1;

  logic                                reg_wr;
  logic                                reg_rd;
  logic                                ctrl_wr;
  logic                                running;
  logic                                stall;
  logic [accel_pkg::IO_DATA_WIDTH-1:0] rd_mux;

  assign reg_wr  = req.en && req.wen && !req.addr[MEM_SEL];
  assign reg_rd  = req.en && !req.wen;
  assign ctrl_wr = reg_wr && (req.addr == accel_pkg::REG_CTRL) && req.strb[0];

  // the scan counts as running from the start strobe onwards
  assign running = start || status.busy;

  // memory window writes go straight through in the request cycle
  assign mem_we    = req.en && req.wen && req.addr[MEM_SEL];
  assign mem_line  = req.addr[11:4];
  assign mem_lane  = req.addr[3:2];
  assign mem_strb  = req.strb;
  assign mem_wdata = req.wr_data;

  always_ff @(posedge clk) begin
    if (reg_wr) begin
      case (req.addr)
        accel_pkg::REG_LEN: begin
          desc.len <= req.wr_data[accel_pkg::LEN_WIDTH-1:0];
        end
        accel_pkg::REG_ADDR: begin
          desc.line_addr <= req.wr_data[accel_pkg::LINE_ADDR_WIDTH-1:0];
        end
        accel_pkg::REG_PATTERN: begin
          pattern <= req.wr_data[7:0];
        end
        default: begin
        end
      endcase
    end
  end

  // one-cycle strobes, start is dropped while a scan runs
  always_ff @(posedge clk) begin
    if (rst) begin
      start <= 1'b0;
      stop  <= 1'b0;
    end else begin
      start <= ctrl_wr && req.wr_data[0] && !req.wr_data[4] && !running;
      stop  <= ctrl_wr && req.wr_data[4];
    end
  end

  always_comb begin
    rd_mux = '0;
    case (req.addr)
      accel_pkg::REG_CTRL: begin
        rd_mux[1] = status.busy;
        rd_mux[8] = status.done;
        rd_mux[9] = status.match;
      end
      accel_pkg::REG_LEN:     rd_mux[accel_pkg::LEN_WIDTH-1:0] = desc.len;
      accel_pkg::REG_ADDR:    rd_mux[accel_pkg::LINE_ADDR_WIDTH-1:0] = desc.line_addr;
      accel_pkg::REG_PATTERN: rd_mux[7:0] = pattern;
      accel_pkg::REG_COUNT:   rd_mux[accel_pkg::STAT_WIDTH-1:0] = status.count;
      accel_pkg::REG_FIRST:   rd_mux[accel_pkg::STAT_WIDTH-1:0] = status.first_index;
      // memory window and unused offsets read as zero
      default: begin
      end
    endcase
  end

  // host holds the address during a stall, so the mux still selects FIRST
  always_ff @(posedge clk) begin
    if (stall ? status.done : reg_rd) begin
      rd_data <= rd_mux;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
      stall    <= 1'b0;
    end else begin
      rd_valid <= 1'b0;
      if (stall) begin
        if (status.done) begin
          rd_valid <= 1'b1;
          stall    <= 1'b0;
        end
      end else if (reg_rd) begin
        if (req.addr == accel_pkg::REG_FIRST && running) begin
          stall <= 1'b1;
        end else begin
          rd_valid <= 1'b1;
        end
      end
    end
  end

endmodule

/* verilog/accel_pkg.sv */
package accel_pkg;

  // host register port
  localparam int IO_DATA_WIDTH = 32;
  localparam int IO_STRB_WIDTH = IO_DATA_WIDTH / 8;
  localparam int IO_ADDR_WIDTH = 13;

  // packet memory and datapath
  localparam int LINE_WIDTH      = 128;
  localparam int WORD_WIDTH      = 64;
  localparam int LEN_WIDTH       = 14;
  localparam int LINE_ADDR_WIDTH = 8;
  localparam int LANE_WIDTH      = 2;
  localparam int STAT_WIDTH      = 16;

  // register byte offsets, bit 12 clear
  localparam logic [IO_ADDR_WIDTH-1:0] REG_CTRL    = 13'h000;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_LEN     = 13'h004;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_ADDR    = 13'h008;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_PATTERN = 13'h00c;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_COUNT   = 13'h010;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_FIRST   = 13'h014;

  localparam logic [STAT_WIDTH-1:0] NO_MATCH = '1;

  typedef struct packed {
    logic                     en;
    logic                     wen;
    logic [IO_STRB_WIDTH-1:0] strb;
    logic [IO_ADDR_WIDTH-1:0] addr;
    logic [IO_DATA_WIDTH-1:0] wr_data;
  } io_req_t;

  typedef struct packed {
    logic [LINE_ADDR_WIDTH-1:0] line_addr;
    logic [LEN_WIDTH-1:0]       len;
  } dma_desc_t;

  // nbytes runs 1 to 16
  typedef struct packed {
    logic [LINE_WIDTH-1:0] data;
    logic [4:0]            nbytes;
    logic                  last;
  } line_beat_t;

  typedef struct packed {
    logic [WORD_WIDTH-1:0]   data;
    logic [WORD_WIDTH/8-1:0] keep;
    logic                    last;
  } word_beat_t;

  typedef struct packed {
    logic                  busy;
    logic                  done;
    logic                  match;
    logic [STAT_WIDTH-1:0] count;
    logic [STAT_WIDTH-1:0] first_index;
  } scan_status_t;

endpackage
